/* verilog/zx_audio_pkg.sv */
package zx_audio_pkg;

  // bus and sample widths
  localparam int addr_w   = 16;
  localparam int data_w   = 8;
  localparam int sample_w = 16;

  // z80 i/o address, seen either as one word or as two bytes
  // ports decode on the low byte; the high byte carries row or register selects
  typedef union packed {
    logic [addr_w-1:0] word;
    struct packed {
      logic [data_w-1:0] hi;
      logic [data_w-1:0] lo;
    } half;
  } io_addr_t;

  // low-byte port numbers
  localparam logic [data_w-1:0] port_ula      = 8'hFE;
  localparam logic [data_w-1:0] port_covox_a  = 8'h0F;
  localparam logic [data_w-1:0] port_covox_b  = 8'h1F;
  localparam logic [data_w-1:0] port_covox_c  = 8'h4F;
  localparam logic [data_w-1:0] port_covox_d  = 8'h5F;
  localparam logic [data_w-1:0] port_covox_fb = 8'hFB;

  // bits of the #FE write byte
  localparam int ula_tape_bit    = 3;
  localparam int ula_speaker_bit = 4;

  // tape input position in the #FE read byte
  localparam int ula_tape_in_bit = 6;

  // floating bus value for ports nobody claims
  localparam logic [data_w-1:0] bus_idle = 8'hFF;

  // fixed levels mixed into both channels
  localparam logic [sample_w-1:0] speaker_level = 16'h2000;
  localparam logic [sample_w-1:0] tape_level    = 16'h1000;

  // 8-bit covox value lands at bits 12:5 of the sample
  localparam int covox_shift = 5;

  // psg_mix codes; 2 and 3 both give swapped stereo
  localparam logic [1:0] mix_stereo = 2'd0;
  localparam logic [1:0] mix_mono   = 2'd1;

endpackage

/* verilog/z80_io_sync.sv */
`timescale 1ns/100ps

module z80_io_sync (
  input  logic                           clk_28mhz,
  input  logic                           rst,
  input  logic                           iorq_n,
  input  logic                           rd_n,
  input  logic                           wr_n,
  input  zx_audio_pkg::io_addr_t         addr,
  input  logic [zx_audio_pkg::data_w-1:0] data_in,
  input  logic                           tape_in,
  output logic                           wr_stb,
  output logic                           rd_stb,
  output zx_audio_pkg::io_addr_t         io_addr,
  output logic [zx_audio_pkg::data_w-1:0] wr_data,
  output logic                           tape_in_s
);

  // two-flop synchronizers, strobes idle high
  logic iorq_meta, iorq_sync;
  logic rd_meta, rd_sync;
  logic wr_meta, wr_sync;
  logic tape_meta;

  // cycle-active levels and their previous values
  logic wr_act, rd_act;
  logic wr_act_q, rd_act_q;
  logic wr_start, rd_start;

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      iorq_meta <= 1'b1;
      iorq_sync <= 1'b1;
      rd_meta   <= 1'b1;
      rd_sync   <= 1'b1;
      wr_meta   <= 1'b1;
      wr_sync   <= 1'b1;
      tape_meta <= 1'b0;
      tape_in_s <= 1'b0;
    end else begin
      iorq_meta <= iorq_n;
      iorq_sync <= iorq_meta;
      rd_meta   <= rd_n;
      rd_sync   <= rd_meta;
      wr_meta   <= wr_n;
      wr_sync   <= wr_meta;
      tape_meta <= tape_in;
      tape_in_s <= tape_meta;
    end
  end

  assign wr_act = ~iorq_sync & ~wr_sync;
  assign rd_act = ~iorq_sync & ~rd_sync;

  // rising edge of the active level, so one strobe per bus cycle
  assign wr_start = wr_act & ~wr_act_q;
  assign rd_start = rd_act & ~rd_act_q;

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      wr_act_q <= 1'b0;
      rd_act_q <= 1'b0;
      wr_stb   <= 1'b0;
      rd_stb   <= 1'b0;
    end else begin
      wr_act_q <= wr_act;
      rd_act_q <= rd_act;
      wr_stb   <= wr_start;
      rd_stb   <= rd_start;
    end
  end

  // bus has been stable for two clocks by now, safe to take it raw
  always_ff @(posedge clk_28mhz) begin
    if (wr_start | rd_start) begin
      io_addr <= addr;
    end
    if (wr_start) begin
      wr_data <= data_in;
    end
  end

endmodule

/* verilog/zx_port_regs.sv */
`timescale 1ns/100ps

module zx_port_regs (
  input  logic                            clk_28mhz,
  input  logic                            rst,
  input  logic                            wr_stb,
  input  logic                            rd_stb,
  input  zx_audio_pkg::io_addr_t          io_addr,
  input  logic [zx_audio_pkg::data_w-1:0] wr_data,
  input  logic                            covox_en,
  input  logic                            tape_in_s,
  output logic [zx_audio_pkg::data_w-1:0] rd_data,
  output logic                            tape_out,
  output logic                            speaker,
  output logic [zx_audio_pkg::data_w-1:0] covox_a,
  output logic [zx_audio_pkg::data_w-1:0] covox_b,
  output logic [zx_audio_pkg::data_w-1:0] covox_c,
  output logic [zx_audio_pkg::data_w-1:0] covox_d,
  output logic [zx_audio_pkg::data_w-1:0] covox_fb,
  output logic                            tape_in_q
);

  logic [zx_audio_pkg::data_w-1:0] port_lo;

  // address hits
  logic hit_ula;
  logic hit_cvx_a;
  logic hit_cvx_b;
  logic hit_cvx_c;
  logic hit_cvx_d;
  logic hit_cvx_fb;

  // covox writes only count while the switch is on
  logic cvx_wr;

  logic [zx_audio_pkg::data_w-1:0] ula_rd_byte;
  logic [zx_audio_pkg::data_w-1:0] rd_next;

  // high byte is don't care for every port here
  assign port_lo = io_addr.half.lo;

  assign hit_ula    = (port_lo == zx_audio_pkg::port_ula);
  assign hit_cvx_a  = (port_lo == zx_audio_pkg::port_covox_a);
  assign hit_cvx_b  = (port_lo == zx_audio_pkg::port_covox_b);
  assign hit_cvx_c  = (port_lo == zx_audio_pkg::port_covox_c);
  assign hit_cvx_d  = (port_lo == zx_audio_pkg::port_covox_d);
  assign hit_cvx_fb = (port_lo == zx_audio_pkg::port_covox_fb);

  assign cvx_wr = wr_stb & covox_en;

  // ula port write
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      tape_out <= 1'b0;
      speaker  <= 1'b0;
    end else if (wr_stb && hit_ula) begin
      tape_out <= wr_data[zx_audio_pkg::ula_tape_bit];
      speaker  <= wr_data[zx_audio_pkg::ula_speaker_bit];
    end
  end

  // covox dac channels
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      covox_a  <= '0;
      covox_b  <= '0;
      covox_c  <= '0;
      covox_d  <= '0;
      covox_fb <= '0;
    end else if (cvx_wr) begin
      if (hit_cvx_a) begin
        covox_a <= wr_data;
      end
      if (hit_cvx_b) begin
        covox_b <= wr_data;
      end
      if (hit_cvx_c) begin
        covox_c <= wr_data;
      end
      if (hit_cvx_d) begin
        covox_d <= wr_data;
      end
      if (hit_cvx_fb) begin
        covox_fb <= wr_data;
      end
    end
  end

  // #FE read: floating bus with the tape level on bit 6
  always_comb begin
    ula_rd_byte = zx_audio_pkg::bus_idle;
    ula_rd_byte[zx_audio_pkg::ula_tape_in_bit] = tape_in_s;
  end

  // covox ports are write only and read back as idle bus
  assign rd_next = hit_ula ? ula_rd_byte : zx_audio_pkg::bus_idle;

  // read byte held until the next read
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      rd_data <= zx_audio_pkg::bus_idle;
    end else if (rd_stb) begin
      rd_data <= rd_next;
    end
  end

  // tape level on to the mixer
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      tape_in_q <= 1'b0;
    end else begin
      tape_in_q <= tape_in_s;
    end
  end

endmodule

/* verilog/zx_audio_mixer.sv */
`timescale 1ns/100ps

module zx_audio_mixer (
  input  logic                              clk_28mhz,
  input  logic                              rst,
  input  logic                              speaker,
  input  logic                              tape_in_q,
  input  logic [zx_audio_pkg::data_w-1:0]   covox_a,
  input  logic [zx_audio_pkg::data_w-1:0]   covox_b,
  input  logic [zx_audio_pkg::data_w-1:0]   covox_c,
  input  logic [zx_audio_pkg::data_w-1:0]   covox_d,
  input  logic [zx_audio_pkg::data_w-1:0]   covox_fb,
  input  logic [1:0]                        psg_mix,
  output logic [zx_audio_pkg::sample_w-1:0] audio_l,
  output logic [zx_audio_pkg::sample_w-1:0] audio_r
);

  // covox channels widened and scaled
  logic [zx_audio_pkg::sample_w-1:0] cvx_a;
  logic [zx_audio_pkg::sample_w-1:0] cvx_b;
  logic [zx_audio_pkg::sample_w-1:0] cvx_c;
  logic [zx_audio_pkg::sample_w-1:0] cvx_d;
  logic [zx_audio_pkg::sample_w-1:0] cvx_fb;

  // channel pairs without the fb channel
  logic [zx_audio_pkg::sample_w-1:0] grp_ab;
  logic [zx_audio_pkg::sample_w-1:0] grp_cd;

  // speaker and tape levels common to both sides
  logic [zx_audio_pkg::sample_w-1:0] base;

  logic [zx_audio_pkg::sample_w-1:0] mix_l;
  logic [zx_audio_pkg::sample_w-1:0] mix_r;

  function automatic logic [zx_audio_pkg::sample_w-1:0] covox_term(
    input logic [zx_audio_pkg::data_w-1:0] v
  );
    logic [zx_audio_pkg::sample_w-1:0] wide;
    wide = '0;
    wide[zx_audio_pkg::data_w-1:0] = v;
    return wide << zx_audio_pkg::covox_shift;
  endfunction

  assign cvx_a  = covox_term(covox_a);
  assign cvx_b  = covox_term(covox_b);
  assign cvx_c  = covox_term(covox_c);
  assign cvx_d  = covox_term(covox_d);
  assign cvx_fb = covox_term(covox_fb);

  assign grp_ab = cvx_a + cvx_b;
  assign grp_cd = cvx_c + cvx_d;

  assign base = (speaker   ? zx_audio_pkg::speaker_level : '0) +
                (tape_in_q ? zx_audio_pkg::tape_level    : '0);

  // worst case 5*8160 + #2000 + #1000 = 53088 fits in 16 bits
  always_comb begin
    case (psg_mix)
      zx_audio_pkg::mix_stereo: begin
        mix_l = grp_ab + cvx_fb;
        mix_r = grp_cd + cvx_fb;
      end
      zx_audio_pkg::mix_mono: begin
        mix_l = grp_ab + grp_cd + cvx_fb;
        mix_r = grp_ab + grp_cd + cvx_fb;
      end
      default: begin
        // swapped stereo
        mix_l = grp_cd + cvx_fb;
        mix_r = grp_ab + cvx_fb;
      end
    endcase
  end

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      audio_l <= '0;
      audio_r <= '0;
    end else begin
      audio_l <= mix_l + base;
      audio_r <= mix_r + base;
    end
  end

endmodule

/* verilog/zx_audio_top.sv */
`timescale 1ns/100ps

module zx_audio_top (
  input  logic                              clk_28mhz,
  input  logic                              rst,
  input  logic                              iorq_n,
  input  logic                              rd_n,
  input  logic                              wr_n,
  input  zx_audio_pkg::io_addr_t            addr,
  input  logic [zx_audio_pkg::data_w-1:0]   data_in,
  input  logic                              tape_in,
  input  logic                              covox_en,
  input  logic [1:0]                        psg_mix,
  output logic [zx_audio_pkg::data_w-1:0]   data_out,
  output logic                              tape_out,
  output logic                              beep,
  output logic [zx_audio_pkg::sample_w-1:0] audio_l,
  output logic [zx_audio_pkg::sample_w-1:0] audio_r
);

  // synchronizer to port registers
  logic                            wr_stb;
  logic                            rd_stb;
  zx_audio_pkg::io_addr_t          io_addr;
  logic [zx_audio_pkg::data_w-1:0] wr_data;
  logic                            tape_in_s;

  // port registers to mixer
  logic [zx_audio_pkg::data_w-1:0] covox_a;
  logic [zx_audio_pkg::data_w-1:0] covox_b;
  logic [zx_audio_pkg::data_w-1:0] covox_c;
  logic [zx_audio_pkg::data_w-1:0] covox_d;
  logic [zx_audio_pkg::data_w-1:0] covox_fb;
  logic                            tape_in_q;

  z80_io_sync u_sync (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .iorq_n    (iorq_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .addr      (addr),
    .data_in   (data_in),
    .tape_in   (tape_in),
    .wr_stb    (wr_stb),
    .rd_stb    (rd_stb),
    .io_addr   (io_addr),
    .wr_data   (wr_data),
    .tape_in_s (tape_in_s)
  );

  // speaker bit drives the beeper pin directly
  zx_port_regs u_regs (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .wr_stb    (wr_stb),
    .rd_stb    (rd_stb),
    .io_addr   (io_addr),
    .wr_data   (wr_data),
    .covox_en  (covox_en),
    .tape_in_s (tape_in_s),
    .rd_data   (data_out),
    .tape_out  (tape_out),
    .speaker   (beep),
    .covox_a   (covox_a),
    .covox_b   (covox_b),
    .covox_c   (covox_c),
    .covox_d   (covox_d),
    .covox_fb  (covox_fb),
    .tape_in_q (tape_in_q)
  );

  zx_audio_mixer u_mixer (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .speaker   (beep),
    .tape_in_q (tape_in_q),
    .covox_a   (covox_a),
    .covox_b   (covox_b),
    .covox_c   (covox_c),
    .covox_d   (covox_d),
    .covox_fb  (covox_fb),
    .psg_mix   (psg_mix),
    .audio_l   (audio_l),
    .audio_r   (audio_r)
  );

endmodule

/* include/tb_zx_checks.svh */
`ifndef TB_ZX_CHECKS_SVH
`define TB_ZX_CHECKS_SVH

// z80 write cycle: strobes low for 4 clocks, then 4 idle clocks
task automatic io_write(input logic [zx_audio_pkg::data_w-1:0] port,
                        input logic [zx_audio_pkg::data_w-1:0] value);
  zx_audio_pkg::io_addr_t a;
  a.half.hi = 8'($urandom);
  a.half.lo = port;
  @(negedge clk_28mhz);
  addr    = a;
  data_in = value;
  iorq_n  = 1'b0;
  wr_n    = 1'b0;
  repeat (4) @(negedge clk_28mhz);
  iorq_n = 1'b1;
  wr_n   = 1'b1;
  repeat (4) @(negedge clk_28mhz);
endtask

// z80 read cycle: strobes low for 6 clocks, byte taken after the idle gap
task automatic io_read(input logic [zx_audio_pkg::data_w-1:0] port,
                       output logic [zx_audio_pkg::data_w-1:0] value);
  zx_audio_pkg::io_addr_t a;
  a.half.hi = 8'($urandom);
  a.half.lo = port;
  @(negedge clk_28mhz);
  addr   = a;
  iorq_n = 1'b0;
  rd_n   = 1'b0;
  repeat (6) @(negedge clk_28mhz);
  iorq_n = 1'b1;
  rd_n   = 1'b1;
  repeat (4) @(negedge clk_28mhz);
  value = data_out;
endtask

task automatic check_byte(input string name,
                          input logic [zx_audio_pkg::data_w-1:0] expected,
                          input logic [zx_audio_pkg::data_w-1:0] actual);
  checks = checks + 1;
  if (actual !== expected) begin
    errors = errors + 1;
    $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
  end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
  checks = checks + 1;
  if (actual !== expected) begin
    errors = errors + 1;
    $display("CHECK FAILED: %s expected %b actual %b", name, expected, actual);
  end
endtask

task automatic check_sample(input string name,
                            input logic [zx_audio_pkg::sample_w-1:0] expected,
                            input logic [zx_audio_pkg::sample_w-1:0] actual);
  checks = checks + 1;
  if (actual !== expected) begin
    errors = errors + 1;
    $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
  end
endtask

`endif

/* testbench/tb_zx_audio.sv */
`timescale 1ns/100ps

module tb_zx_audio;

  // 5 tests of 40 bus cycles at 20 clocks each
  localparam int num_tests   = 5;
  localparam int watchdog_ns = num_tests * 40 * 20 * 8;

  logic                              clk_28mhz;
  logic                              rst;
  logic                              iorq_n;
  logic                              rd_n;
  logic                              wr_n;
  zx_audio_pkg::io_addr_t            addr;
  logic [zx_audio_pkg::data_w-1:0]   data_in;
  logic                              tape_in;
  logic                              covox_en;
  logic [1:0]                        psg_mix;
  logic [zx_audio_pkg::data_w-1:0]   data_out;
  logic                              tape_out;
  logic                              beep;
  logic [zx_audio_pkg::sample_w-1:0] audio_l;
  logic [zx_audio_pkg::sample_w-1:0] audio_r;

  int checks;
  int errors;

  // reference model state for speaker, tape level and covox a b c d fb
  logic                            spk_m;
  logic                            tape_m;
  logic [zx_audio_pkg::data_w-1:0] cvx_m [5];

  `include "tb_zx_checks.svh"

  zx_audio_top u_dut (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .iorq_n    (iorq_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .addr      (addr),
    .data_in   (data_in),
    .tape_in   (tape_in),
    .covox_en  (covox_en),
    .psg_mix   (psg_mix),
    .data_out  (data_out),
    .tape_out  (tape_out),
    .beep      (beep),
    .audio_l   (audio_l),
    .audio_r   (audio_r)
  );

  initial begin
    clk_28mhz = 1'b0;
    forever #4 clk_28mhz = ~clk_28mhz;
  end

  initial begin
    #(watchdog_ns);
    $display("ERROR: watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic settle();
    repeat (8) @(negedge clk_28mhz);
  endtask

  function automatic logic [zx_audio_pkg::data_w-1:0] cvx_port(input int idx);
    case (idx)
      0: return zx_audio_pkg::port_covox_a;
      1: return zx_audio_pkg::port_covox_b;
      2: return zx_audio_pkg::port_covox_c;
      3: return zx_audio_pkg::port_covox_d;
      default: return zx_audio_pkg::port_covox_fb;
    endcase
  endfunction

  // sample expected on one side from the mixing rule
  function automatic logic [zx_audio_pkg::sample_w-1:0] expected_side(input logic [1:0] mode,
                                                                      input bit right);
    int v [5];
    int i;
    int ab_fb;
    int cd_fb;
    int sum;
    for (i = 0; i < 5; i++) begin
      v[i] = int'(cvx_m[i]) << zx_audio_pkg::covox_shift;
    end
    ab_fb = v[0] + v[1] + v[4];
    cd_fb = v[2] + v[3] + v[4];
    case (mode)
      zx_audio_pkg::mix_stereo: sum = right ? cd_fb : ab_fb;
      zx_audio_pkg::mix_mono:   sum = v[0] + v[1] + v[2] + v[3] + v[4];
      default:                  sum = right ? ab_fb : cd_fb;
    endcase
    if (spk_m) begin
      sum = sum + int'(zx_audio_pkg::speaker_level);
    end
    if (tape_m) begin
      sum = sum + int'(zx_audio_pkg::tape_level);
    end
    return sum[zx_audio_pkg::sample_w-1:0];
  endfunction

  task automatic verify_audio(input string name);
    check_sample({name, " audio_l"}, expected_side(psg_mix, 1'b0), audio_l);
    check_sample({name, " audio_r"}, expected_side(psg_mix, 1'b1), audio_r);
  endtask

  task automatic after_reset();
    logic [zx_audio_pkg::data_w-1:0] rd;
    check_sample("after_reset audio_l", '0, audio_l);
    check_sample("after_reset audio_r", '0, audio_r);
    check_bit("after_reset tape_out", 1'b0, tape_out);
    check_bit("after_reset beep", 1'b0, beep);
    check_byte("after_reset data_out", zx_audio_pkg::bus_idle, data_out);
    io_read(zx_audio_pkg::port_covox_d, rd);
    check_byte("after_reset read #5F", zx_audio_pkg::bus_idle, rd);
  endtask

  task automatic ula_port_write();
    logic [zx_audio_pkg::data_w-1:0] d;
    int n;
    // random first, then speaker on with tape off, then the reverse
    for (n = 0; n < 3; n++) begin
      d = 8'($urandom);
      if (n == 1) begin
        d[zx_audio_pkg::ula_speaker_bit] = 1'b1;
        d[zx_audio_pkg::ula_tape_bit]    = 1'b0;
      end
      if (n == 2) begin
        d[zx_audio_pkg::ula_speaker_bit] = 1'b0;
        d[zx_audio_pkg::ula_tape_bit]    = 1'b1;
      end
      io_write(zx_audio_pkg::port_ula, d);
      spk_m = d[zx_audio_pkg::ula_speaker_bit];
      settle();
      check_bit("ula_port_write tape_out", d[zx_audio_pkg::ula_tape_bit], tape_out);
      check_bit("ula_port_write beep", d[zx_audio_pkg::ula_speaker_bit], beep);
      verify_audio("ula_port_write");
    end
  endtask

  task automatic covox_stereo_mix();
    logic [zx_audio_pkg::data_w-1:0] d;
    int r;
    int i;
    int m;
    @(negedge clk_28mhz);
    covox_en = 1'b1;
    for (r = 0; r < 2; r++) begin
      for (i = 0; i < 5; i++) begin
        d = 8'($urandom);
        io_write(cvx_port(i), d);
        cvx_m[i] = d;
      end
      for (m = 0; m < 4; m++) begin
        @(negedge clk_28mhz);
        psg_mix = 2'(m);
        settle();
        verify_audio("covox_stereo_mix");
      end
    end
  endtask

  task automatic covox_disabled();
    logic [zx_audio_pkg::data_w-1:0] d;
    int i;
    @(negedge clk_28mhz);
    covox_en = 1'b0;
    psg_mix  = zx_audio_pkg::mix_stereo;
    // each value differs from the stored one so a leaked write shows up
    for (i = 0; i < 5; i++) begin
      d = cvx_m[i] ^ (8'($urandom) | 8'h01);
      io_write(cvx_port(i), d);
    end
    settle();
    verify_audio("covox_disabled");
  endtask

  task automatic tape_input_read();
    logic [zx_audio_pkg::data_w-1:0] rd;
    logic [zx_audio_pkg::data_w-1:0] exp_rd;
    int n;
    logic tv;
    for (n = 0; n < 2; n++) begin
      tv = (n == 0);
      @(negedge clk_28mhz);
      tape_in = tv;
      tape_m  = tv;
      settle();
      io_read(zx_audio_pkg::port_ula, rd);
      exp_rd = zx_audio_pkg::bus_idle;
      exp_rd[zx_audio_pkg::ula_tape_in_bit] = tv;
      check_byte("tape_input_read data_out", exp_rd, rd);
      verify_audio("tape_input_read");
    end
    // write-only covox port reads back idle
    io_read(zx_audio_pkg::port_covox_a, rd);
    check_byte("tape_input_read covox read", zx_audio_pkg::bus_idle, rd);
  endtask

  initial begin
    void'($urandom(53));
    checks    = 0;
    errors    = 0;
    rst       = 1'b1;
    iorq_n    = 1'b1;
    rd_n      = 1'b1;
    wr_n      = 1'b1;
    addr      = '0;
    data_in   = '0;
    tape_in   = 1'b0;
    covox_en  = 1'b0;
    psg_mix   = zx_audio_pkg::mix_stereo;
    spk_m     = 1'b0;
    tape_m    = 1'b0;
    for (int i = 0; i < 5; i++) begin
      cvx_m[i] = '0;
    end
    repeat (8) @(negedge clk_28mhz);
    rst = 1'b0;
    settle();

    after_reset();
    ula_port_write();
    covox_stereo_mix();
    covox_disabled();
    tape_input_read();

    $display("run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
verilog/zx_audio_pkg.sv
verilog/z80_io_sync.sv
verilog/zx_port_regs.sv
verilog/zx_audio_mixer.sv
verilog/zx_audio_top.sv
testbench/tb_zx_audio.sv

/* Makefile */
TB_TOP  := tb_zx_audio
RTL_TOP := zx_audio_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timescale 1ns/100ps --top-module $(RTL_TOP) \
	  verilog/zx_audio_pkg.sv verilog/z80_io_sync.sv verilog/zx_port_regs.sv \
	  verilog/zx_audio_mixer.sv verilog/zx_audio_top.sv

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TB_TOP) \
	  -f sim.f --Mdir obj_dir -o $(TB_TOP)
	./obj_dir/$(TB_TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
